/* common/seg7Pkg.sv */
package seg7Pkg;

	//////////////////////////////
	// Timing
	//////////////////////////////

	// Clock cycles per scan step, kept small for simulation
	localparam logic [15:0] SCAN_DIV = 16'd16;

	// Scan steps per blink half-period, longer than one serial frame
	localparam logic [7:0] BLINK_DIV = 8'd32;

	// Serial frame length, one byte per digit
	localparam int FRAME_BITS = 64;

	//////////////////////////////
	// Register map
	//////////////////////////////

	localparam logic [1:0] ADDR_DATA   = 2'd0;
	localparam logic [1:0] ADDR_POINT  = 2'd1;
	localparam logic [1:0] ADDR_LES    = 2'd2;
	localparam logic [1:0] ADDR_STATUS = 2'd3;

	// One DATA word seen as hex digits or as raw segment bits
	typedef union packed {
		logic [7:0][3:0] nibbles;
		logic [31:0]     raw;
	} dispWord_t;

	// Hex digit to segments gfedcba, 1 lights the segment
	function automatic logic [6:0] segTable(input logic [3:0] hex);
		logic [6:0] seg;
		case (hex)
			4'h0: seg = 7'h3F;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5B;
			4'h3: seg = 7'h4F;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6D;
			4'h6: seg = 7'h7D;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7F;
			4'h9: seg = 7'h6F;
			4'hA: seg = 7'h77;
			4'hB: seg = 7'h7C;
			4'hC: seg = 7'h39;
			4'hD: seg = 7'h5E;
			4'hE: seg = 7'h79;
			default: seg = 7'h71;
		endcase
		return seg;
	endfunction

endpackage

/* common/dispCfgIf.sv */
`timescale 1ns/1ns

// Display settings from the register file to the datapath
interface dispCfgIf import seg7Pkg::*; ();

	dispWord_t  data;
	logic [7:0] point;
	logic [7:0] les;

	// One-cycle request to send a new serial frame
	logic refresh;

	// Shifter still sending
	logic busy;

	modport regs (
		output data,
		output point,
		output les,
		output refresh,
		input  busy
	);

	modport shift (
		input  refresh,
		output busy
	);

	modport view (
		input data,
		input point,
		input les
	);

endinterface

/* seg7/seg7Decode.sv */
`timescale 1ns/1ns

module seg7Decode import seg7Pkg::*; (
	dispCfgIf.view      cfg,
	input  logic        blinkOn,
	output logic [63:0] frame
);

	// Digits dark in the off phase
	logic [7:0] blank;

	assign blank = cfg.les & {8{!blinkOn}};

	//////////////////////////////
	// One byte per digit
	//////////////////////////////

	always_comb
	begin
		for (int k = 0; k < 8; k++)
		begin
			if (blank[k])
				frame[8*k +: 8] = 8'h00;
			else
				frame[8*k +: 8] = {cfg.point[k], segTable(cfg.data.nibbles[k])};
		end
	end

endmodule

/* seg7/seg7Scan.sv */
`timescale 1ns/1ns

module seg7Scan import seg7Pkg::*; (
	input  logic       clkIO,
	input  logic       rstN,
	dispCfgIf.view     cfg,
	output logic       blinkOn,
	output logic       blinkToggle,
	output logic [7:0] segment,
	output logic [1:0] anode
);

	logic [15:0] scanCnt;
	logic [7:0]  blinkCnt;
	logic [1:0]  scanIdx;
	logic        step;

	// Raw word reordered into the four panel bytes
	logic [31:0]     raw;
	logic [3:0][7:0] remap;

	assign raw = cfg.data.raw;

	assign remap[0] = {raw[24], raw[12], raw[5], raw[17], raw[25], raw[16], raw[4], raw[0]};
	assign remap[1] = {raw[26], raw[13], raw[7], raw[19], raw[27], raw[18], raw[6], raw[1]};
	assign remap[2] = {raw[28], raw[14], raw[9], raw[21], raw[29], raw[20], raw[8], raw[2]};
	assign remap[3] = {raw[30], raw[15], raw[11], raw[23], raw[31], raw[22], raw[10], raw[3]};

	assign step = scanCnt == SCAN_DIV - 16'd1;

	//////////////////////////////
	// Prescaler and blink timer
	//////////////////////////////

	always_ff @(posedge clkIO)
	begin
		if (!rstN)
		begin
			scanCnt     <= 16'h0;
			scanIdx     <= 2'd0;
			blinkCnt    <= 8'h0;
			blinkOn     <= 1'b1;
			blinkToggle <= 1'b0;
		end
		else
		begin
			blinkToggle <= 1'b0;
			if (step)
			begin
				scanCnt <= 16'h0;
				scanIdx <= scanIdx + 2'd1;
				if (blinkCnt == BLINK_DIV - 8'd1)
				begin
					blinkCnt    <= 8'h0;
					blinkOn     <= !blinkOn;
					blinkToggle <= 1'b1;
				end
				else
					blinkCnt <= blinkCnt + 8'd1;
			end
			else
				scanCnt <= scanCnt + 16'd1;
		end
	end

	// Panel drive, active low segments
	always_ff @(posedge clkIO)
	begin
		if (!rstN)
		begin
			segment <= 8'hFF;
			anode   <= 2'd0;
		end
		else
		begin
			segment <= ~remap[scanIdx];
			anode   <= scanIdx;
		end
	end

endmodule

/* seg7/seg7Shifter.sv */
`timescale 1ns/1ns

module seg7Shifter import seg7Pkg::*; (
	input  logic        clkIO,
	input  logic        rstN,
	dispCfgIf.shift     cfg,
	input  logic [63:0] frame,
	output logic [2:0]  sout
);

	localparam int CNT_W = $clog2(FRAME_BITS);

	// Captured frame, MSB goes out first
	logic [63:0] shReg;

	logic [CNT_W-1:0] bitCnt;

	// Low then high half of each serial clock
	logic phase;
	logic latching;
	logic active;

	assign cfg.busy = active;

	// Serial clock, data, latch
	assign sout[2] = active && phase;
	assign sout[1] = active && !latching && shReg[63];
	assign sout[0] = latching;

	//////////////////////////////
	// Serializer
	//////////////////////////////

	always_ff @(posedge clkIO)
	begin
		if (!rstN)
		begin
			active   <= 1'b0;
			latching <= 1'b0;
			phase    <= 1'b0;
			bitCnt   <= '0;
		end
		else if (!active)
		begin
			if (cfg.refresh)
			begin
				active <= 1'b1;
				phase  <= 1'b0;
				bitCnt <= '0;
			end
		end
		else if (latching)
		begin
			latching <= 1'b0;
			active   <= 1'b0;
		end
		else if (!phase)
			phase <= 1'b1;
		else
		begin
			phase  <= 1'b0;
			bitCnt <= bitCnt + 1'b1;
			// Last bit done, pulse the latch next
			if (bitCnt == CNT_W'(FRAME_BITS - 1))
				latching <= 1'b1;
		end
	end

	// Frame data register
	always_ff @(posedge clkIO)
	begin
		if (!active && cfg.refresh)
			shReg <= frame;
		else if (active && !latching && phase)
			shReg <= {shReg[62:0], 1'b0};
	end

	latchNoClk: assert property (@(posedge clkIO) disable iff (!rstN) !(sout[0] && sout[2]));

	// Register side must wait for the frame to finish
	refreshIdle: assert property (@(posedge clkIO) disable iff (!rstN) cfg.refresh |-> !cfg.busy);

endmodule

/* verilog/wbRegs.sv */
`timescale 1ns/1ns

module wbRegs import seg7Pkg::*; (
	input  logic        clkIO,
	input  logic        rstN,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [1:0]  adr,
	input  logic [31:0] datW,
	output logic [31:0] datR,
	output logic        ack,
	input  logic        blinkToggle,
	dispCfgIf.regs      cfg
);

	// New strobe, not yet acknowledged
	logic cycle;

	// Refresh waiting for the shifter
	logic pending;
	logic issue;
	logic newReq;

	// Busy as seen on STATUS, covers the gap before the shifter starts
	logic statusBusy;

	logic [31:0] readMux;

	assign cycle = cyc && stb && !ack;

	// Any display change asks for a new serial frame
	assign newReq = (cycle && we && adr != ADDR_STATUS) || blinkToggle;

	// Hold off while a request is in flight or the shifter runs
	assign issue = pending && !cfg.busy && !cfg.refresh;

	assign statusBusy = cfg.busy || cfg.refresh || pending;

	always_comb
	begin
		case (adr)
			ADDR_DATA:   readMux = cfg.data.raw;
			ADDR_POINT:  readMux = {24'h0, cfg.point};
			ADDR_LES:    readMux = {24'h0, cfg.les};
			ADDR_STATUS: readMux = {31'h0, statusBusy};
		endcase
	end

	//////////////////////////////
	// Bus side
	//////////////////////////////

	always_ff @(posedge clkIO)
	begin
		if (!rstN)
		begin
			ack       <= 1'b0;
			datR      <= 32'h0;
			cfg.data  <= '0;
			cfg.point <= 8'h0;
			cfg.les   <= 8'h0;
		end
		else
		begin
			ack  <= cycle;
			datR <= (cycle && !we) ? readMux : 32'h0;
			if (cycle && we)
			begin
				case (adr)
					ADDR_DATA:  cfg.data  <= datW;
					ADDR_POINT: cfg.point <= datW[7:0];
					ADDR_LES:   cfg.les   <= datW[7:0];
					// STATUS is read only
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// Refresh pacing
	//////////////////////////////

	always_ff @(posedge clkIO)
	begin
		if (!rstN)
		begin
			pending     <= 1'b0;
			cfg.refresh <= 1'b0;
		end
		else
		begin
			cfg.refresh <= issue;
			// A request in the same cycle as the issue stays pending
			if (newReq)
				pending <= 1'b1;
			else if (issue)
				pending <= 1'b0;
		end
	end

	// One ack per strobe
	ackSingle: assert property (@(posedge clkIO) disable iff (!rstN) ack |=> !ack);

endmodule

/* verilog/seg7Top.sv */
`timescale 1ns/1ns

module seg7Top (
	input  logic        clkIO,
	input  logic        rstN,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [1:0]  adr,
	input  logic [31:0] datW,
	output logic [31:0] datR,
	output logic        ack,
	output logic [2:0]  sout,
	output logic [7:0]  segment,
	output logic [1:0]  anode
);

	dispCfgIf cfg ();

	// Decoded eight-digit frame for the serial panel
	logic [63:0] frame;

	// Blink phase and its flip pulse
	logic blinkOn;
	logic blinkToggle;

	wbRegs uRegs (
		.clkIO      (clkIO),
		.rstN       (rstN),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.datW       (datW),
		.datR       (datR),
		.ack        (ack),
		.blinkToggle(blinkToggle),
		.cfg        (cfg.regs)
	);

	seg7Decode uDecode (
		.cfg    (cfg.view),
		.blinkOn(blinkOn),
		.frame  (frame)
	);

	seg7Scan uScan (
		.clkIO      (clkIO),
		.rstN       (rstN),
		.cfg        (cfg.view),
		.blinkOn    (blinkOn),
		.blinkToggle(blinkToggle),
		.segment    (segment),
		.anode      (anode)
	);

	seg7Shifter uShifter (
		.clkIO(clkIO),
		.rstN (rstN),
		.cfg  (cfg.shift),
		.frame(frame),
		.sout (sout)
	);

endmodule

/* verif/seg7TbUtil.svh */
`ifndef SEG7_TB_UTIL_SVH
`define SEG7_TB_UTIL_SVH

// Next LCG state
function automatic logic [31:0] lcgStep(input logic [31:0] s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

// Hex digit to gfedcba, lit is 1
function automatic logic [6:0] hexSegs(input logic [3:0] h);
	logic [6:0] t [16];
	t = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
	return t[h];
endfunction

// Scanned panel byte for one index, bits 7 down to 0
function automatic logic [7:0] refRemap(input logic [31:0] r, input logic [1:0] i);
	case (i)
		2'd0: return {r[24], r[12], r[5], r[17], r[25], r[16], r[4], r[0]};
		2'd1: return {r[26], r[13], r[7], r[19], r[27], r[18], r[6], r[1]};
		2'd2: return {r[28], r[14], r[9], r[21], r[29], r[20], r[8], r[2]};
		default: return {r[30], r[15], r[11], r[23], r[31], r[22], r[10], r[3]};
	endcase
endfunction

// Called 1 ns after a rising edge, returns 1 ns after the ack edge
task automatic busCycle(input logic w, input logic [1:0] a, input logic [31:0] d);
	// One idle cycle lets the previous ack drop
	@(posedge clkIO);
	#1;
	cyc = 1'b1;
	stb = 1'b1;
	we = w;
	adr = a;
	datW = d;
	@(posedge clkIO);
	#1;
	checkHex("ack", {63'h0, ack}, 64'h1);
	readVal = datR;
	cyc = 1'b0;
	stb = 1'b0;
	we = 1'b0;
endtask

`endif

/* verif/seg7Tb.sv */
`timescale 1ns/1ns

module seg7Tb import seg7Pkg::*; ();

	localparam int NUM_TESTS = 10;
	localparam int PHASE_CYC = int'(BLINK_DIV) * int'(SCAN_DIV);

	logic        clkIO;
	logic        rstN;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [1:0]  adr;
	logic [31:0] datW;
	logic [31:0] datR;
	logic        ack;
	logic [2:0]  sout;
	logic [7:0]  segment;
	logic [1:0]  anode;

	// Register shadows and the copy taken at refresh
	logic [31:0] shData;
	logic [7:0]  shPoint;
	logic [7:0]  shLes;
	logic [31:0] fData;
	logic [7:0]  fPoint;
	logic [7:0]  fLes;
	logic [31:0] readVal;
	logic [31:0] seed;
	logic [63:0] bits;
	int          bitCount;
	int          latchCount;
	int          toggleCount;
	logic        blankSeen;
	logic        litSeen;
	logic        busStarted;
	logic        rstSeen;
	logic [1:0]  prevAnode;
	logic [31:0] prevData;

	seg7Top dut (.*);

	task automatic stopFail();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic checkHex(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stopFail();
		end
	endtask

	task automatic checkTrue(input logic ok, input string what);
		assert (ok)
		else
		begin
			$display("%s", what);
			stopFail();
		end
	endtask

	`include "seg7TbUtil.svh"

	task automatic writeReg(input logic [1:0] a, input logic [31:0] d);
		busCycle(1'b1, a, d);
		case (a)
			ADDR_DATA:  shData = d;
			ADDR_POINT: shPoint = d[7:0];
			ADDR_LES:   shLes = d[7:0];
			default: ;
		endcase
	endtask

	// Poll STATUS until the shifter and any pending request are done
	task automatic waitIdle();
		do
		begin
			busCycle(1'b0, ADDR_STATUS, 32'h0);
			checkHex("datR[31:1]", {33'h0, readVal[31:1]}, 64'h0);
		end
		while (readVal[0]);
	endtask

	initial
	begin
		clkIO = 1'b0;
	end

	always #4 clkIO = !clkIO;

	ackNext: assert property (@(posedge clkIO) disable iff (!rstN) $rose(stb) |=> ack)
		else
		begin
			$display("Strobe was not acknowledged in the next cycle");
			stopFail();
		end
	ackOnly: assert property (@(posedge clkIO) disable iff (!rstN) ack |-> $past(cyc && stb))
		else
		begin
			$display("Acknowledge seen without a strobe in the cycle before");
			stopFail();
		end
	latchOnce: assert property (@(posedge clkIO) disable iff (!rstN) sout[0] |=> !sout[0])
		else
		begin
			$display("Latch pulse lasted more than one cycle");
			stopFail();
		end

	//////////////////////////////
	// Output monitors
	//////////////////////////////

	always @(negedge clkIO)
	begin
		if (rstSeen && !busStarted)
		begin
			checkHex("ack", {63'h0, ack}, 64'h0);
			checkHex("sout", {61'h0, sout}, 64'h0);
			checkHex("anode", {62'h0, anode}, 64'h0);
			checkHex("segment", {56'h0, segment}, 64'hFF);
		end
		if (rstN)
		begin
			if (anode != prevAnode)
				checkHex("segment", {56'h0, segment}, {56'h0, ~refRemap(prevData, anode)});
			if (dut.cfg.refresh)
			begin
				fData = shData;
				fPoint = shPoint;
				fLes = shLes;
				bitCount = 0;
			end
			if (dut.blinkToggle)
				toggleCount++;
			if (sout[2])
			begin
				bits = {bits[62:0], sout[1]};
				bitCount++;
			end
			if (sout[0])
			begin
				checkHex("serial bit count", bitCount, 64);
				for (int k = 0; k < 8; k++)
				begin
					if (fLes[k] && bits[8*k +: 8] == 8'h00)
						blankSeen = 1'b1;
					else
					begin
						checkHex("frame byte", bits[8*k +: 8],
							{fPoint[k], hexSegs(fData[4*k +: 4])});
						if (fLes[k])
							litSeen = 1'b1;
					end
				end
				latchCount++;
			end
		end
		prevAnode = anode;
		prevData = shData;
	end

	// Watchdog sized from the frame and scan lengths
	initial
	begin
		#(8 * (NUM_TESTS * (129 + 2 * int'(SCAN_DIV) * 4) * 4 + 4 * PHASE_CYC * NUM_TESTS + 4000));
		$display("Watchdog timeout, the run did not finish in time");
		stopFail();
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial
	begin
		rstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 2'd0;
		datW = 32'h0;
		shData = 32'h0;
		shPoint = 8'h0;
		shLes = 8'h0;
		seed = 32'd90233;
		bitCount = 0;
		latchCount = 0;
		toggleCount = 0;
		busStarted = 1'b0;
		rstSeen = 1'b0;
		blankSeen = 1'b0;
		litSeen = 1'b0;
		@(posedge clkIO);
		rstSeen = 1'b1;
		repeat (3) @(posedge clkIO);
		#1;
		rstN = 1'b1;
		repeat (2) @(posedge clkIO);
		#1;
		busStarted = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			// Start each burst from an idle shifter
			waitIdle();
			latchCount = 0;
			toggleCount = 0;
			// Burst of writes merges into few frames
			seed = lcgStep(seed);
			writeReg(ADDR_DATA, seed);
			seed = lcgStep(seed);
			writeReg(ADDR_POINT, {24'h0, seed[15:8]});
			seed = lcgStep(seed);
			writeReg(ADDR_LES, (t % 2 == 1) ? {24'h0, seed[23:16] | 8'h01} : 32'h0);
			busCycle(1'b0, ADDR_STATUS, 32'h0);
			checkHex("datR", readVal, 32'h1);
			waitIdle();
			checkTrue(latchCount >= 1, "No latch pulse after a register write");
			checkTrue(latchCount <= 2 + toggleCount, "Too many frames for one burst of writes");
			busCycle(1'b0, ADDR_DATA, 32'h0);
			checkHex("datR", readVal, shData);
			busCycle(1'b0, ADDR_POINT, 32'h0);
			checkHex("datR", readVal, {24'h0, shPoint});
			busCycle(1'b0, ADDR_LES, 32'h0);
			checkHex("datR", readVal, {24'h0, shLes});
			if (shLes != 8'h0)
			begin
				blankSeen = 1'b0;
				litSeen = 1'b0;
				// Blink phase length is fixed by the dividers
				repeat (4 * PHASE_CYC) @(posedge clkIO);
				#1;
				checkTrue(blankSeen && litSeen, "Blinking digits not seen both dark and lit");
			end
		end
		$display("Test OK");
		$finish;
	end

endmodule

/* files.f */
+incdir+verif
common/seg7Pkg.sv
common/dispCfgIf.sv
seg7/seg7Decode.sv
seg7/seg7Scan.sv
seg7/seg7Shifter.sv
verilog/wbRegs.sv
verilog/seg7Top.sv
verif/seg7Tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the seven-segment testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module seg7Tb -Mdir build -f files.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./build/Vseg7Tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi

exit 0
